//--- build.f
verilog/alu_pkg.sv
verilog/carry_ripple_unit.sv
verilog/reduce_tree.sv
verilog/equality_compare.sv
verilog/chunked_alu.sv
dv/chunked_alu_asserts.sv
dv/chunked_alu_tb.sv

//--- Makefile
# Verilator build and run for the chunked alu testbench

VERILATOR ?= verilator
TOP       ?= chunked_alu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# pass only if the run prints the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/chunked_alu_tb.sv
////////////////////
// chunked alu testbench: directed and random vectors, each held
// until settled and compared against a reference model
////////////////////

`timescale 1ns/100ps

module chunked_alu_tb
    import alu_pkg::*;
();

    ////////////////////
    // run limits
    ////////////////////

    // clocks of rst at start and on the mid-run reset
    localparam int reset_cycles = 3;
    // random a/b/c vectors
    localparam int random_count = 200;
    // about 220 vectors at settle_cycles+1 clocks each, plus resets,
    // roughly doubled for margin
    localparam int timeout_cycles = 2000;

    // expected results for one vector
    typedef struct packed {
        logic [data_width-1:0] sum;
        logic [data_width-1:0] diff;
        logic                  and_r;
        logic                  or_r;
        logic                  xor_r;
        logic                  eq;
        logic                  neq;
    } expected_t;

    logic      clk;
    logic      rst;
    operand_u  a;
    operand_u  b;
    operand_u  c;
    operand_u  sum;
    operand_u  diff;
    logic      gate_and;
    logic      gate_or;
    logic      gate_xor;
    logic      cmp_eq;
    logic      cmp_neq;

    // compare process runs only while this is high
    logic      check_en;
    expected_t exp_r;
    string     test_name;
    integer    seed;
    int        error_count;
    int        check_count;
    int        vector_count;
    int        cycle_count;

    ////////////////////
    // dut and checkers
    ////////////////////

    chunked_alu i_dut (
        .clk      (clk),
        .rst      (rst),
        .a        (a),
        .b        (b),
        .c        (c),
        .sum      (sum),
        .diff     (diff),
        .gate_and (gate_and),
        .gate_or  (gate_or),
        .gate_xor (gate_xor),
        .cmp_eq   (cmp_eq),
        .cmp_neq  (cmp_neq)
    );

    // settle and hold checks ride along inside the dut
    bind chunked_alu chunked_alu_asserts i_asserts (
        .clk      (clk),
        .rst      (rst),
        .a        (a),
        .b        (b),
        .c        (c),
        .sum      (sum),
        .diff     (diff),
        .gate_and (gate_and),
        .gate_or  (gate_or),
        .gate_xor (gate_xor),
        .cmp_eq   (cmp_eq),
        .cmp_neq  (cmp_neq)
    );

    // 10 ns period
    always #5 clk = ~clk;

    ////////////////////
    // reference and compare
    ////////////////////

    // arithmetic wraps modulo 2**32, reductions are over all of a
    function automatic expected_t alu_reference(
        input logic [data_width-1:0] op_a,
        input logic [data_width-1:0] op_b,
        input logic [data_width-1:0] op_c
    );
        expected_t r;
        r.sum   = op_a + op_b;
        r.diff  = op_a - op_b;
        r.and_r = &op_a;
        r.or_r  = |op_a;
        r.xor_r = ^op_a;
        r.eq    = (op_a == op_c);
        r.neq   = (op_a != op_c);
        return r;
    endfunction

    task automatic check_value(
        input string                 name,
        input string                 field,
        input logic [data_width-1:0] expected,
        input logic [data_width-1:0] actual
    );
        if (actual !== expected) begin
            $display("FAIL %s %s expected %h actual %h", name, field, expected, actual);
            error_count++;
        end
    endtask

    // falling edge, well away from the drive point after the rising edge
    always @(negedge clk) begin
        if (check_en && !rst) begin
            check_count++;
            check_value(test_name, "sum", exp_r.sum, sum.word);
            check_value(test_name, "diff", exp_r.diff, diff.word);
            check_value(test_name, "gate_and", 32'(exp_r.and_r), 32'(gate_and));
            check_value(test_name, "gate_or", 32'(exp_r.or_r), 32'(gate_or));
            check_value(test_name, "gate_xor", 32'(exp_r.xor_r), 32'(gate_xor));
            check_value(test_name, "cmp_eq", 32'(exp_r.eq), 32'(cmp_eq));
            check_value(test_name, "cmp_neq", 32'(exp_r.neq), 32'(cmp_neq));
            // eq and neq come from separate flops
            check_value(test_name, "eq_neq_differ", 32'd1, 32'(cmp_eq ^ cmp_neq));
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("ERROR: run did not finish within %0d clock cycles", timeout_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    // called at a rising edge, returns at a rising edge.
    // vector is driven 1 ns in, checked in the last of settle_cycles+1
    // clocks, plus extra_hold more checked clocks
    task automatic apply_vector(
        input string                 name,
        input logic [data_width-1:0] va,
        input logic [data_width-1:0] vb,
        input logic [data_width-1:0] vc,
        input int                    extra_hold
    );
        #1;
        rst      = 1'b0;
        check_en = 1'b0;
        a.word   = va;
        b.word   = vb;
        c.word   = vc;
        exp_r     = alu_reference(va, vb, vc);
        test_name = name;
        vector_count++;
        repeat (settle_cycles) @(posedge clk);
        #1;
        check_en = 1'b1;
        repeat (1 + extra_hold) @(posedge clk);
    endtask

    // rst held for reset_cycles edges; next apply_vector releases it
    task automatic apply_reset();
        #1;
        check_en = 1'b0;
        rst      = 1'b1;
        repeat (reset_cycles) @(posedge clk);
    endtask

    initial begin
        logic [data_width-1:0] ra;
        logic [data_width-1:0] rb;
        logic [data_width-1:0] rc;

        seed         = 32'hdc78_751f;
        clk          = 1'b0;
        rst          = 1'b1;
        a            = '0;
        b            = '0;
        c            = '0;
        check_en     = 1'b0;
        exp_r        = '0;
        test_name    = "none";
        error_count  = 0;
        check_count  = 0;
        vector_count = 0;
        cycle_count  = 0;

        repeat (reset_cycles) @(posedge clk);

        // carries and borrows crossing every chunk boundary
        apply_vector("carry_add_wrap", 32'hffff_ffff, 32'h0000_0001, 32'h0, 0);
        apply_vector("carry_sub_wrap", 32'h0000_0000, 32'h0000_0001, 32'h0, 0);
        apply_vector("carry_low_three", 32'h00ff_ffff, 32'h0000_0001, 32'h0, 0);
        apply_vector("borrow_low_three", 32'h0100_0000, 32'h0000_0001, 32'h0, 0);

        // reductions
        apply_vector("red_zeros", 32'h0000_0000, 32'h0, 32'h1, 0);
        apply_vector("red_ones", 32'hffff_ffff, 32'h0, 32'hffff_ffff, 0);
        for (int k = 0; k < chunk_count; k++) begin
            apply_vector($sformatf("red_bit_chunk%0d", k), 32'h1 << (k * chunk_width + k),
                         32'h0, 32'h0, 0);
        end
        // one set bit per chunk, four in total
        apply_vector("red_bit_each_chunk", 32'h0102_0408, 32'h0, 32'h0, 0);
        apply_vector("red_ones_but_top", 32'hfeff_ffff, 32'h1, 32'h0, 0);

        // equality, a mismatch confined to one chunk
        apply_vector("eq_same", 32'h1234_5678, 32'h0, 32'h1234_5678, 0);
        apply_vector("eq_top_differs", 32'h1234_5678, 32'h0, 32'h1334_5678, 0);
        apply_vector("eq_bottom_differs", 32'h1234_5678, 32'h0, 32'h1234_5679, 0);

        // outputs must stay put while the vector is held
        apply_vector("hold_stable", 32'hdead_beef, 32'h1357_9bdf, 32'hdead_beef, 3);

        // random vectors, c equal to a on every fourth
        for (int i = 0; i < random_count; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            rc = $random(seed);
            if (i % 4 == 3) begin
                rc = ra;
            end
            // mid-run reset, the vector after it must still settle in time
            if (i == random_count / 2) begin
                apply_reset();
                apply_vector("after_reset", ra, rb, rc, 0);
            end else begin
                apply_vector($sformatf("random_%0d", i), ra, rb, rc, 0);
            end
        end

        #1;
        check_en = 1'b0;
        @(posedge clk);

        $display("vectors: %0d  checks: %0d  errors: %0d",
                 vector_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- dv/chunked_alu_asserts.sv
////////////////////
// chunked alu checks: settled results and hold stability
////////////////////

`timescale 1ns/100ps

module chunked_alu_asserts
    import alu_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input operand_u a,
    input operand_u b,
    input operand_u c,
    input operand_u sum,
    input operand_u diff,
    input logic     gate_and,
    input logic     gate_or,
    input logic     gate_xor,
    input logic     cmp_eq,
    input logic     cmp_neq
);

    // operands seen at the previous edge
    logic [3*data_width-1:0] prev_in;
    // operands at this edge match the ones at the previous edge
    logic                    same_in;
    // edges in a row with unchanged operands, saturates one past settle
    int                      stable_cnt;
    logic                    settled;
    logic                    held;

    assign same_in = ({a, b, c} == prev_in);

    always_ff @(posedge clk) begin
        prev_in <= {a, b, c};
        if (rst) begin
            stable_cnt <= 0;
        end else if (!same_in) begin
            stable_cnt <= 0;
        end else if (stable_cnt <= settle_cycles) begin
            stable_cnt <= stable_cnt + 1;
        end
    end

    // outputs correct once the operands sat still over settle_cycles+1 edges
    assign settled = same_in && (stable_cnt >= settle_cycles - 1);
    // held means the outputs were already correct one edge earlier
    assign held    = same_in && (stable_cnt >= settle_cycles);

    sum_settled: assert property (@(posedge clk) disable iff (rst)
        settled |-> (sum.word == a.word + b.word))
        else $error("sum not equal to a + b after settle time");

    diff_settled: assert property (@(posedge clk) disable iff (rst)
        settled |-> (diff.word == a.word - b.word))
        else $error("diff not equal to a - b after settle time");

    eq_neq_differ: assert property (@(posedge clk) disable iff (rst)
        settled |-> (cmp_eq != cmp_neq))
        else $error("cmp_eq and cmp_neq agree after settle time");

    outputs_hold: assert property (@(posedge clk) disable iff (rst)
        held |-> $stable({sum, diff, gate_and, gate_or, gate_xor, cmp_eq, cmp_neq}))
        else $error("outputs changed while operands were held");

endmodule

//--- verilog/chunked_alu.sv
////////////////////
// chunked alu: add, subtract, reductions and equality, each
// settled settle_cycles clocks after the operands stop changing
////////////////////

`timescale 1ns/100ps

module chunked_alu
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    // operands are levels held by the environment
    input  operand_u a,
    input  operand_u b,
    input  operand_u c,
    output operand_u sum,
    output operand_u diff,
    output logic     gate_and,
    output logic     gate_or,
    output logic     gate_xor,
    output logic     cmp_eq,
    output logic     cmp_neq
);

    ////////////////////
    // arithmetic
    ////////////////////

    // a + b
    carry_ripple_unit #(.subtract(0)) i_add (
        .clk    (clk),
        .rst    (rst),
        .a      (a),
        .b      (b),
        .result (sum)
    );

    // a - b
    carry_ripple_unit #(.subtract(1)) i_sub (
        .clk    (clk),
        .rst    (rst),
        .a      (a),
        .b      (b),
        .result (diff)
    );

    ////////////////////
    // reductions of a
    ////////////////////

    reduce_tree #(.op(red_and)) i_red_and (
        .clk(clk), .rst(rst), .a(a), .result(gate_and)
    );

    reduce_tree #(.op(red_or)) i_red_or (
        .clk(clk), .rst(rst), .a(a), .result(gate_or)
    );

    reduce_tree #(.op(red_xor)) i_red_xor (
        .clk(clk), .rst(rst), .a(a), .result(gate_xor)
    );

    ////////////////////
    // a against c
    ////////////////////

    equality_compare i_cmp (
        .clk (clk),
        .rst (rst),
        .a   (a),
        .c   (c),
        .eq  (cmp_eq),
        .neq (cmp_neq)
    );

endmodule

//--- verilog/equality_compare.sv
////////////////////
// equality compare: chunk-wise match of a and c folded by a
// registered AND tree into separate eq and neq registers
////////////////////

`timescale 1ns/100ps

module equality_compare
    import alu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  operand_u a,
    input  operand_u c,
    output logic     eq,
    output logic     neq
);

    ////////////////////
    // chunk matches
    ////////////////////

    // high when chunk k of a matches chunk k of c
    logic [chunk_count-1:0] match_d;
    logic [chunk_count-1:0] match_q;
    // and of each group of tree_fan_in matches
    logic [pair_count-1:0]  pair_q;

    always_comb begin
        for (int k = 0; k < chunk_count; k++) begin
            match_d[k] = (a.chunk[k] == c.chunk[k]);
        end
    end

    ////////////////////
    // and tree
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            match_q <= '0;
            pair_q  <= '0;
        end else begin
            // edge 1
            match_q <= match_d;
            // edge 2, fan-in-2 and of neighbouring chunks
            for (int i = 0; i < pair_count; i++) begin
                pair_q[i] <= &match_q[i*tree_fan_in +: tree_fan_in];
            end
        end
    end

    // edge 3: last unit feeds two registers, eq and its complement.
    // neq gets its own flop instead of an inverter behind eq
    always_ff @(posedge clk) begin
        if (rst) begin
            // both low straight out of reset
            eq  <= 1'b0;
            neq <= 1'b0;
        end else begin
            eq  <= &pair_q;
            neq <= ~&pair_q;
        end
    end

    // once settled, exactly one of eq and neq is high

endmodule

//--- verilog/reduce_tree.sv
////////////////////
// reduce tree: per-chunk bit reduction, then a registered
// fan-in-2 tree down to one output bit
////////////////////

`timescale 1ns/100ps

module reduce_tree
    import alu_pkg::*;
#(
    // red_and, red_or or red_xor
    parameter int op = red_and
) (
    input  logic     clk,
    input  logic     rst,
    input  operand_u a,
    output logic     result
);

    // level 1, one bit per chunk
    logic [chunk_count-1:0] chunk_q;
    // level 2, one bit per pair of chunks
    logic [pair_count-1:0]  pair_q;

    ////////////////////
    // operators
    ////////////////////

    // whole chunk down to one bit
    function automatic logic reduce_chunk(input logic [chunk_width-1:0] bits);
        logic r;
        case (op)
            red_or:  r = |bits;
            red_xor: r = ^bits;
            default: r = &bits;
        endcase
        return r;
    endfunction

    // one combining unit of the tree, same operator as the chunks
    function automatic logic combine(input logic [tree_fan_in-1:0] bits);
        logic r;
        case (op)
            red_or:  r = |bits;
            red_xor: r = ^bits;
            default: r = &bits;
        endcase
        return r;
    endfunction

    ////////////////////
    // pipeline
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            chunk_q <= '0;
            pair_q  <= '0;
            result  <= 1'b0;
        end else begin
            // edge 1, chunk reductions
            for (int k = 0; k < chunk_count; k++) begin
                chunk_q[k] <= reduce_chunk(a.chunk[k]);
            end
            // edge 2, neighbouring chunks combined
            for (int i = 0; i < pair_count; i++) begin
                pair_q[i] <= combine(chunk_q[i*tree_fan_in +: tree_fan_in]);
            end
            // edge 3, final unit into the output register
            result <= combine(pair_q);
        end
    end

    // stages always advance, so successive inputs can be in flight at once

endmodule

//--- verilog/carry_ripple_unit.sv
////////////////////
// carry ripple unit: chunked add or subtract, carry registered
// between chunks so a full carry ripples one chunk per clock
////////////////////

`timescale 1ns/100ps

module carry_ripple_unit
    import alu_pkg::*;
#(
    // 0 gives a + b, 1 gives a - b
    parameter int subtract = 0
) (
    input  logic     clk,
    input  logic     rst,
    input  operand_u a,
    input  operand_u b,
    output operand_u result
);

    ////////////////////
    // chunk arithmetic
    ////////////////////

    // each chunk result keeps one extra bit for the carry or borrow out
    logic [chunk_count-1:0][chunk_width:0] chunk_full;
    // carry into each chunk, chunk 0 always starts clean
    logic [chunk_count-1:0]                carry_in;
    // registered carries at the chunk boundaries
    logic [chunk_count-1:1]                carry_q;

    assign carry_in = {carry_q, 1'b0};

    always_comb begin
        for (int k = 0; k < chunk_count; k++) begin
            if (subtract != 0) begin
                // borrow out shows up as the extra top bit going high
                chunk_full[k] = {1'b0, a.chunk[k]} - {1'b0, b.chunk[k]}
                              - {{chunk_width{1'b0}}, carry_in[k]};
            end else begin
                chunk_full[k] = {1'b0, a.chunk[k]} + {1'b0, b.chunk[k]}
                              + {{chunk_width{1'b0}}, carry_in[k]};
            end
            result.chunk[k] = chunk_full[k][chunk_width-1:0];
        end
    end

    ////////////////////
    // carry registers
    ////////////////////

    // carry out of the top chunk is dropped, result wraps modulo 2**32
    always_ff @(posedge clk) begin
        if (rst) begin
            carry_q <= '0;
        end else begin
            for (int k = 1; k < chunk_count; k++) begin
                // chunk k sees the carry of chunk k-1 one clock later
                carry_q[k] <= chunk_full[k-1][chunk_width];
            end
        end
    end

    // chunk k is right k clocks after a and b settle

endmodule

//--- verilog/alu_pkg.sv
////////////////////
// alu package: widths, chunking and settle time shared by the
// chunked arithmetic blocks, plus the operand word/chunk union
////////////////////

package alu_pkg;

    ////////////////////
    // datapath geometry
    ////////////////////

    // full operand width
    localparam int data_width = 32;
    // one chunk of logic between registers
    localparam int chunk_width = 8;
    localparam int chunk_count = data_width / chunk_width;

    ////////////////////
    // combining trees
    ////////////////////

    // inputs per combining unit in the reduction and equality trees
    localparam int tree_fan_in = 2;
    // results left after the first combining level
    localparam int pair_count = chunk_count / tree_fan_in;
    // registered levels, chunk stage included
    localparam int tree_depth = 3;

    // clocks after the last input change until every output is correct.
    // the carry ripple needs chunk_count-1, the trees need tree_depth
    localparam int settle_cycles =
        (chunk_count - 1 > tree_depth) ? (chunk_count - 1) : tree_depth;

    ////////////////////
    // reduction selectors
    ////////////////////

    // values for the op parameter of reduce_tree
    localparam int red_and = 0;
    localparam int red_or  = 1;
    localparam int red_xor = 2;

    ////////////////////
    // operand views
    ////////////////////

    // same 32 bits seen as a flat word or as chunks, chunk 0 at the lsb
    typedef union packed {
        logic [data_width-1:0]                   word;
        logic [chunk_count-1:0][chunk_width-1:0] chunk;
    } operand_u;

endpackage
